//--- logic/periph_pkg.sv
// Peripheral wrapper shared types: address map, slot numbers, access sizes and address views
`default_nettype none

package periph_pkg;

    localparam int PIN_COUNT  = 8;
    localparam int SLOT_COUNT = 16;

    // Slot numbers of the implemented peripherals
    localparam logic [3:0] SLOT_GPIO = 4'd1;
    localparam logic [3:0] SLOT_EDGE = 4'd1;

    // GPIO register offsets, pin n select lives at GPIO_SEL_OFS + 4n
    localparam logic [5:0] GPIO_OUT_OFS = 6'd0;
    localparam logic [5:0] GPIO_IN_OFS  = 6'd4;
    localparam logic [5:0] GPIO_SEL_OFS = 6'd32;

    // Edge counter register offsets
    localparam logic [3:0] EDGE_COUNT_OFS = 4'd0;
    localparam logic [3:0] EDGE_PIN_OFS   = 4'd1;

    // Active-low access size as driven by the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_IDLE = 2'd3
    } size_n_t;

    // User region: 16 slots of 64 bytes below bit 10
    typedef struct packed {
        logic       region;
        logic [3:0] slot;
        logic [5:0] offset;
    } user_addr_t;

    // Simple region: 16 byte slots of 16 bytes with bit 10 set
    typedef struct packed {
        logic       region;
        logic [1:0] spare;
        logic [3:0] slot;
        logic [3:0] offset;
    } simple_addr_t;

    typedef union packed {
        user_addr_t   user;
        simple_addr_t simple;
    } addr_t;

    // Output pin source, top bit picks the simple region
    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
    } func_sel_t;

endpackage

`default_nettype wire

//--- logic/periph_bus_if.sv
// Peripheral bus between the address decoder and one peripheral slot
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if
    import periph_pkg::*;
();

    // Decoder to peripheral
    addr_t                addr;
    logic [31:0]          wdata;
    logic                 wr;
    logic                 rd;

    // Peripheral to decoder
    logic [31:0]          rdata;
    logic                 ready;

    // Pin outputs, picked up by the GPIO output mux
    logic [PIN_COUNT-1:0] pins;

    modport decoder (
        output addr,
        output wdata,
        output wr,
        output rd,
        input  rdata,
        input  ready
    );

    modport periph (
        input  addr,
        input  wdata,
        input  wr,
        input  rd,
        output rdata,
        output ready,
        output pins
    );

endinterface

`default_nettype wire

//--- logic/periph_decode.sv
// Address decoder with per-slot strobes, read mux and a held, registered read result
`timescale 1ns/1ps
`default_nettype none

module periph_decode
    import periph_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,

    input  wire  [10:0]       i_addr,
    input  wire  [31:0]       i_data,
    input  wire  [1:0]        i_data_write_n,
    input  wire  [1:0]        i_data_read_n,
    input  wire               i_data_read_complete,

    output logic [31:0]       o_data,
    output logic              o_data_ready,

    periph_bus_if.decoder     gpio_bus,
    periph_bus_if.decoder     edge_bus
);

    addr_t                 addr;
    size_n_t               wr_size;
    size_n_t               rd_size;
    logic                  write_req;
    logic                  read_req;

    logic [SLOT_COUNT-1:0] user_sel;
    logic [SLOT_COUNT-1:0] simple_sel;

    logic [31:0]           slot_rdata;
    logic                  slot_ready;
    logic                  capture;

    logic                  hold;
    logic                  ready_q;
    logic [31:0]           data_q;

    assign addr    = i_addr;
    assign wr_size = size_n_t'(i_data_write_n);
    assign rd_size = size_n_t'(i_data_read_n);

    assign write_req = (wr_size != SIZE_IDLE);
    assign read_req  = (rd_size != SIZE_IDLE);

    // One-hot slot select within the addressed region
    always_comb begin
        user_sel   = '0;
        simple_sel = '0;
        if (addr.simple.region) begin
            simple_sel[addr.simple.slot] = 1'b1;
        end else begin
            user_sel[addr.user.slot] = 1'b1;
        end
    end

    // Read mux, empty slots return zero and are always ready
    always_comb begin
        slot_rdata = '0;
        slot_ready = 1'b1;
        if (simple_sel[SLOT_EDGE]) begin
            slot_rdata = {24'h0, edge_bus.rdata[7:0]};
            slot_ready = edge_bus.ready;
        end else if (user_sel[SLOT_GPIO]) begin
            slot_rdata = gpio_bus.rdata;
            slot_ready = gpio_bus.ready;
        end
    end

    // Address and write data go to every slot, strobes only to the selected one
    assign gpio_bus.addr  = addr;
    assign gpio_bus.wdata = i_data;
    assign gpio_bus.wr    = write_req && user_sel[SLOT_GPIO];
    // No read strobe while a result is still buffered
    assign gpio_bus.rd    = read_req && !hold && user_sel[SLOT_GPIO];

    assign edge_bus.addr  = addr;
    assign edge_bus.wdata = i_data;
    assign edge_bus.wr    = write_req && simple_sel[SLOT_EDGE];
    assign edge_bus.rd    = read_req && !hold && simple_sel[SLOT_EDGE];

    assign capture = !hold && read_req && slot_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_q <= read_req && slot_ready;
        end
    end

    // Result held here so the peripheral sees a single-cycle read
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= slot_rdata;
        end
    end

    assign o_data       = data_q;
    assign o_data_ready = ready_q || write_req;

    // Buffered result must not move before the core completes the read
    assert property (@(posedge clk) disable iff (!rst_n)
        hold && !i_data_read_complete |=> $stable(o_data));

    assert property (@(posedge clk) disable iff (!rst_n)
        !(gpio_bus.rd && edge_bus.rd));

endmodule

`default_nettype wire

//--- logic/gpio_port.sv
// GPIO peripheral with output register, input read-back, pin function selects and output mux
`timescale 1ns/1ps
`default_nettype none

module gpio_port
    import periph_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire  [PIN_COUNT-1:0] i_ui_in,
    input  wire  [PIN_COUNT-1:0] i_edge_pins,
    output logic [PIN_COUNT-1:0] o_uo_out,

    periph_bus_if.periph         bus
);

    // Selects sit at 32 + 4n, word aligned
    localparam logic [5:0] SEL_MASK = 6'b100011;

    // Every pin starts on the GPIO output register
    localparam func_sel_t SEL_RESET = '{simple: 1'b0, slot: SLOT_GPIO};

    logic [5:0]           offset;
    logic                 sel_hit;
    logic [2:0]           sel_idx;

    logic [PIN_COUNT-1:0] gpio_out;
    func_sel_t            sel_q [PIN_COUNT];

    assign offset  = bus.addr.user.offset;
    assign sel_hit = ((offset & SEL_MASK) == GPIO_SEL_OFS);
    assign sel_idx = offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < PIN_COUNT; i++) begin
                sel_q[i] <= SEL_RESET;
            end
        end else if (bus.wr) begin
            if (offset == GPIO_OUT_OFS) begin
                gpio_out <= bus.wdata[PIN_COUNT-1:0];
            end
            if (sel_hit) begin
                sel_q[sel_idx] <= func_sel_t'(bus.wdata[4:0]);
            end
        end
    end

    // Register read-back
    always_comb begin
        bus.rdata = '0;
        if (offset == GPIO_OUT_OFS) begin
            bus.rdata = {{(32-PIN_COUNT){1'b0}}, gpio_out};
        end else if (offset == GPIO_IN_OFS) begin
            bus.rdata = {{(32-PIN_COUNT){1'b0}}, i_ui_in};
        end else if (sel_hit) begin
            bus.rdata = {27'h0, sel_q[sel_idx]};
        end
    end

    assign bus.ready = 1'b1;
    assign bus.pins  = gpio_out;

    // Each pin takes the bit of its own index from the source its select names
    always_comb begin
        func_sel_t sel;
        o_uo_out = '0;
        for (int i = 0; i < PIN_COUNT; i++) begin
            sel = sel_q[i];
            if (!sel.simple && sel.slot == SLOT_GPIO) begin
                o_uo_out[i] = bus.pins[i];
            end else if (sel.simple && sel.slot == SLOT_EDGE) begin
                o_uo_out[i] = i_edge_pins[i];
            end
        end
    end

    // A select write shows up on the read path from the next cycle on
    assert property (@(posedge clk) disable iff (!rst_n)
        bus.wr && sel_hit |=>
            (offset != $past(offset)) || (bus.rdata == {27'h0, $past(bus.wdata[4:0])}));

endmodule

`default_nettype wire

//--- logic/edge_counter.sv
// Byte peripheral counting rising edges on one selectable input pin
`timescale 1ns/1ps
`default_nettype none

module edge_counter
    import periph_pkg::*;
#(
    parameter int SYNC_STAGES = 2
)
(
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire  [PIN_COUNT-1:0] i_ui_in,

    periph_bus_if.periph         bus
);

    logic [3:0]             offset;
    logic [7:0]             wbyte;

    logic [2:0]             pin_sel;
    logic [SYNC_STAGES-1:0] sync_q;
    logic                   sync_out;
    logic                   prev_q;
    logic                   rise;
    logic [7:0]             count;

    assign offset = bus.addr.simple.offset;
    assign wbyte  = bus.wdata[7:0];

    // Input sync chain, then one flop for the edge compare
    assign sync_out = sync_q[SYNC_STAGES-1];
    assign rise     = sync_out && !prev_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel <= '0;
            sync_q  <= '0;
            prev_q  <= 1'b0;
            count   <= '0;
        end else begin
            sync_q <= (sync_q << 1) | SYNC_STAGES'(i_ui_in[pin_sel]);
            prev_q <= sync_out;

            // Any write to the count clears it, wins over a new edge
            if (bus.wr && offset == EDGE_COUNT_OFS) begin
                count <= '0;
            end else if (rise) begin
                count <= count + 8'd1;
            end

            if (bus.wr && offset == EDGE_PIN_OFS) begin
                pin_sel <= wbyte[2:0];
            end
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (offset == EDGE_COUNT_OFS) begin
            bus.rdata = {24'h0, count};
        end else if (offset == EDGE_PIN_OFS) begin
            bus.rdata = {29'h0, pin_sel};
        end
    end

    assign bus.ready = 1'b1;
    assign bus.pins  = count;

endmodule

`default_nettype wire

//--- logic/periph_top.sv
// Peripheral wrapper top level joining the decoder, the GPIO port and the edge counter
`timescale 1ns/1ps
`default_nettype none

module periph_top
    import periph_pkg::*;
#(
    parameter int SYNC_STAGES = 2
)
(
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire  [PIN_COUNT-1:0] i_ui_in,
    output logic [PIN_COUNT-1:0] o_uo_out,

    input  wire  [10:0]          i_addr,
    input  wire  [31:0]          i_data,
    input  wire  [1:0]           i_data_write_n,
    input  wire  [1:0]           i_data_read_n,
    input  wire                  i_data_read_complete,

    output logic [31:0]          o_data,
    output logic                 o_data_ready
);

    // One bus per implemented peripheral
    periph_bus_if gpio_bus ();
    periph_bus_if edge_bus ();

    periph_decode u_decode (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready),
        .gpio_bus             (gpio_bus.decoder),
        .edge_bus             (edge_bus.decoder)
    );

    // User slot 1
    gpio_port u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ui_in     (i_ui_in),
        .i_edge_pins (edge_bus.pins),
        .o_uo_out    (o_uo_out),
        .bus         (gpio_bus.periph)
    );

    // Simple slot 1
    edge_counter #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_edge (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_ui_in (i_ui_in),
        .bus     (edge_bus.periph)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// Testbench clock source with a 100 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD = 100.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2.0) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
// Peripheral wrapper testbench driving random bus traffic against a register model
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import periph_pkg::*;
();

    localparam int SYNC_STAGES = 2;
    localparam int SETTLE      = SYNC_STAGES + 3;
    localparam int RANDOM_OPS  = 300;
    // Directed accesses plus the random ones, 20 cycles each at most
    localparam int NUM_OPS     = 112 + RANDOM_OPS;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_ui_in;
    logic [10:0] i_addr;
    logic [31:0] i_data;
    logic [1:0]  i_data_write_n;
    logic [1:0]  i_data_read_n;
    logic        i_data_read_complete;
    logic [7:0]  o_uo_out;
    logic [31:0] o_data;
    logic        o_data_ready;

    // Model state
    logic [7:0]  m_out;
    logic [7:0]  m_ui;
    logic [2:0]  m_pin;
    logic [7:0]  m_count;
    func_sel_t   m_sel [PIN_COUNT];

    tb_clock u_clock (
        .o_clk (clk)
    );

    periph_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) uut (.*);

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail o_data: got 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic check_pins(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail o_uo_out: got 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail o_data_ready: got 0x%h, expected 0x%h", got, exp));
        end
    endtask

    // Expected read data from the address map
    function automatic logic [31:0] model_read(input addr_t a);
        logic [5:0] ofs;
        ofs = a.user.offset;
        if (a.simple.region) begin
            if (a.simple.slot == SLOT_EDGE && a.simple.offset == EDGE_COUNT_OFS) begin
                return {24'h0, m_count};
            end
            if (a.simple.slot == SLOT_EDGE && a.simple.offset == EDGE_PIN_OFS) begin
                return {29'h0, m_pin};
            end
        end else if (a.user.slot == SLOT_GPIO) begin
            if (ofs == GPIO_OUT_OFS) begin
                return {24'h0, m_out};
            end
            if (ofs == GPIO_IN_OFS) begin
                return {24'h0, m_ui};
            end
            // Select n sits at 32 + 4n
            if (ofs[5] && ofs[1:0] == 2'b00) begin
                return {27'h0, m_sel[ofs[4:2]]};
            end
        end
        return '0;
    endfunction

    function automatic logic [7:0] model_pins();
        logic [7:0] pins;
        pins = '0;
        for (int i = 0; i < PIN_COUNT; i++) begin
            if (m_sel[i] == {1'b0, SLOT_GPIO}) begin
                pins[i] = m_out[i];
            end else if (m_sel[i] == {1'b1, SLOT_EDGE}) begin
                pins[i] = m_count[i];
            end
        end
        return pins;
    endfunction

    // Called just after a rising edge, a rise on the watched pin bumps the count
    task automatic set_inputs(input logic [7:0] value);
        if (!m_ui[m_pin] && value[m_pin]) begin
            m_count = m_count + 8'd1;
        end
        m_ui = value;
        i_ui_in <= value;
    endtask

    // Let the edge sync chain drain, then compare the pins
    task automatic settle();
        repeat (SETTLE) @(posedge clk);
        @(negedge clk);
        check_pins(o_uo_out, model_pins());
    endtask

    task automatic write_access(input addr_t a, input logic [31:0] data);
        logic [2:0] pin;
        @(posedge clk);
        i_addr         <= a;
        i_data         <= data;
        i_data_write_n <= 2'($urandom_range(2));
        @(negedge clk);
        check_ready(o_data_ready, 1'b1);
        @(posedge clk);
        i_data_write_n <= SIZE_IDLE;
        pin = data[2:0];
        if (a.simple.region && a.simple.slot == SLOT_EDGE) begin
            if (a.simple.offset == EDGE_COUNT_OFS) begin
                m_count = '0;
            end else if (a.simple.offset == EDGE_PIN_OFS) begin
                // Switching pins looks like an edge when the new pin is high
                if (!m_ui[m_pin] && m_ui[pin]) begin
                    m_count = m_count + 8'd1;
                end
                m_pin = pin;
            end
        end else if (!a.user.region && a.user.slot == SLOT_GPIO) begin
            if (a.user.offset == GPIO_OUT_OFS) begin
                m_out = data[7:0];
            end else if (a.user.offset[5] && a.user.offset[1:0] == 2'b00) begin
                m_sel[a.user.offset[4:2]] = func_sel_t'(data[4:0]);
            end
        end
        settle();
    endtask

    task automatic read_access(input addr_t a, input logic hold_check);
        logic [31:0] expected;
        int          cycles;
        @(posedge clk);
        i_addr        <= a;
        i_data_read_n <= 2'($urandom_range(2));
        @(negedge clk);
        check_ready(o_data_ready, 1'b0);
        expected = model_read(a);
        cycles   = 0;
        while (!o_data_ready && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles != 1) begin
            report_failure($sformatf("Read ready came after %0d cycles instead of one", cycles));
        end
        check_data(o_data, expected);
        // Inputs move while the result is held
        if (hold_check) begin
            repeat (2) begin
                @(posedge clk);
                set_inputs(8'($urandom));
                @(negedge clk);
                check_data(o_data, expected);
            end
        end
        @(posedge clk);
        i_data_read_complete <= 1'b1;
        @(posedge clk);
        i_data_read_complete <= 1'b0;
        i_data_read_n        <= SIZE_IDLE;
        settle();
    endtask

    // Mostly implemented registers, the rest anywhere in the map
    function automatic addr_t random_addr();
        addr_t a;
        a = 11'($urandom);
        case ($urandom_range(3))
            0: begin
                a.user.region = 1'b0;
                a.user.slot   = SLOT_GPIO;
                a.user.offset = ($urandom_range(1) == 0) ? 6'(32 + 4 * $urandom_range(7))
                                                         : 6'(4 * $urandom_range(1));
            end
            1: begin
                a.simple.region = 1'b1;
                a.simple.slot   = SLOT_EDGE;
                a.simple.offset = 4'($urandom_range(2));
            end
            default: ;
        endcase
        return a;
    endfunction

    initial begin
        func_sel_t sel;
        void'($urandom(1995));
        rst_n                = 1'b0;
        i_ui_in              = '0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = SIZE_IDLE;
        i_data_read_n        = SIZE_IDLE;
        i_data_read_complete = 1'b0;
        m_out                = '0;
        m_ui                 = '0;
        m_pin                = '0;
        m_count              = '0;
        for (int i = 0; i < PIN_COUNT; i++) begin
            m_sel[i] = {1'b0, SLOT_GPIO};
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        settle();
        check_ready(o_data_ready, 1'b0);

        // GPIO output read-back, every pin still follows it
        for (int n = 0; n < 8; n++) begin
            write_access({1'b0, SLOT_GPIO, GPIO_OUT_OFS}, $urandom);
            read_access({1'b0, SLOT_GPIO, GPIO_OUT_OFS}, 1'b0);
        end
        for (int n = 0; n < 4; n++) begin
            read_access({1'b0, SLOT_GPIO, GPIO_IN_OFS}, 1'b1);
        end

        // Edge counter on random pins
        for (int n = 0; n < 4; n++) begin
            write_access({1'b1, 2'b00, SLOT_EDGE, EDGE_PIN_OFS}, $urandom);
            repeat (4) begin
                @(posedge clk);
                set_inputs(8'($urandom));
                settle();
            end
            read_access({1'b1, 2'b00, SLOT_EDGE, EDGE_COUNT_OFS}, 1'b0);
            write_access({1'b1, 2'b00, SLOT_EDGE, EDGE_COUNT_OFS}, $urandom);
            read_access({1'b1, 2'b00, SLOT_EDGE, EDGE_COUNT_OFS}, 1'b0);
        end

        for (int i = 0; i < PIN_COUNT; i++) begin
            case ($urandom_range(2))
                0: sel = {1'b0, SLOT_GPIO};
                1: sel = {1'b1, SLOT_EDGE};
                default: sel = 5'($urandom);
            endcase
            write_access({1'b0, SLOT_GPIO, 6'(GPIO_SEL_OFS + 4 * i)}, {27'($urandom), sel});
            read_access({1'b0, SLOT_GPIO, 6'(GPIO_SEL_OFS + 4 * i)}, 1'b0);
        end

        // Empty slots in both regions
        for (int s = 0; s < SLOT_COUNT; s++) begin
            if (s != SLOT_GPIO) begin
                write_access({1'b0, 4'(s), 6'($urandom)}, $urandom);
                read_access({1'b0, 4'(s), 6'($urandom)}, 1'b0);
            end
            if (s != SLOT_EDGE) begin
                write_access({1'b1, 2'($urandom), 4'(s), 4'($urandom)}, $urandom);
                read_access({1'b1, 2'($urandom), 4'(s), 4'($urandom)}, 1'b0);
            end
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            if ($urandom_range(1) == 1) begin
                @(posedge clk);
                set_inputs(8'($urandom));
                settle();
            end
            if ($urandom_range(1) == 1) begin
                write_access(random_addr(), $urandom);
            end else begin
                read_access(random_addr(), 1'($urandom_range(1)));
            end
        end
        $display("Verification passed");
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 20 + 100) @(posedge clk);
        report_failure("Timed out before all tests finished");
    end

endmodule

`default_nettype wire

//--- tb.f
logic/periph_pkg.sv
logic/periph_bus_if.sv
logic/periph_decode.sv
logic/gpio_port.sv
logic/edge_counter.sv
logic/periph_top.sv
bench/tb_clock.sv
bench/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
